// ==== bench/rename_core_asserts.sv ====
// --------------------
// Concurrent checks on the rename stage bound into rename_core
// --------------------

module rename_core_asserts
    import isa_pkg::*, rename_pkg::*;
(
    input logic   clk_i,
    input logic   rstn_i,
    input logic   valid_i,
    input logic   write_rd_i,
    input reg_t   rd_i,
    input logic   do_recover_i,
    input logic   recover_commit_i,
    input logic   valid_o,
    input phreg_t new_dst_o,
    input logic   stall_o,
    input logic   out_of_chk_i,   // Table has no copy left
    input logic   do_chk_i
);

    stall_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$isunknown(stall_o))
        else $error("stall_o is unknown");

    // Nothing renamed while the map is rolled back
    quiet_after_recovery: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (do_recover_i || recover_commit_i) |=> !valid_o)
        else $error("valid_o high in the cycle after a recovery");

    // Only instructions that wrote a real register
    new_dst_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (valid_o && $past(valid_i && write_rd_i && (rd_i != '0)))
            |-> (new_dst_o >= phreg_t'(NUM_ISA_REGISTERS)))
        else $error("new_dst_o points at an architectural register");

    no_checkpoint_when_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(out_of_chk_i && do_chk_i))
        else $error("Checkpoint taken with no copy free");

endmodule

bind rename_core rename_core_asserts u_asserts (
    .clk_i, .rstn_i, .valid_i, .write_rd_i, .rd_i,
    .do_recover_i, .recover_commit_i, .valid_o, .new_dst_o, .stall_o,
    .out_of_chk_i (u_table_if.out_of_checkpoints),
    .do_chk_i     (u_table_if.do_checkpoint)
);

// ==== bench/rename_tests.txt ====
# name valid rs1 rs2 rd use1 use2 wr br | wb0 v r p | wb1 v r p | cw crd cnew crel cold | rec rchk del rcom
# then expected: valid src1 rdy1 src2 rdy2 old new chk stall (all hex)
reset_id  1 03 04 00 1 1 0 0 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 03 1 04 1 00 20 0 0
ren_x1    1 01 02 01 1 1 1 0 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 01 1 02 1 01 20 0 0
ren_x2    1 01 00 02 1 0 1 0 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 20 0 00 1 02 21 0 0
rd_zero   1 02 01 00 1 1 1 0 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 21 0 20 0 00 22 0 0
wb_bypass 1 01 02 00 1 1 0 0 1 01 20 0 00 00 0 00 00 0 00 0 0 0 0 1 20 1 21 0 00 22 0 0
wb_port1  1 01 02 00 1 1 0 0 0 00 00 1 02 21 0 00 00 0 00 0 0 0 0 1 20 1 21 1 00 22 0 0
ren_x3    1 01 02 03 1 1 1 0 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 20 1 21 1 03 22 0 0
branch    1 03 00 04 1 0 1 1 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 22 0 00 1 04 23 0 0
spec_x1   1 04 00 01 1 0 1 0 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 23 0 00 1 20 24 1 0
spec_x2   1 01 00 02 1 0 1 0 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 24 0 00 1 21 25 1 0
recover   0 00 00 00 0 0 0 0 0 00 00 0 00 00 0 00 00 0 00 1 0 0 0 0 00 0 00 0 00 00 1 0
post_rec  1 04 02 01 1 1 1 0 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 23 0 21 1 20 24 0 0
commit_x1 0 00 00 00 0 0 0 0 0 00 00 0 00 00 1 01 20 1 01 0 0 0 0 0 00 0 00 0 00 00 0 0
commit_x2 0 00 00 00 0 0 0 0 0 00 00 0 00 00 1 02 21 1 02 0 0 0 0 0 00 0 00 0 00 00 0 0
flush     0 00 00 00 0 0 0 0 0 00 00 0 00 00 0 00 00 0 00 0 0 0 1 0 00 0 00 0 00 00 0 0
cm_read   1 01 02 04 1 1 1 0 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 20 1 21 1 04 22 0 0
cm_alloc  1 03 04 05 1 1 1 0 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 03 1 22 0 05 23 0 0
br_a      1 00 00 00 0 0 0 1 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 00 1 00 1 00 24 0 0
br_b      1 00 00 00 0 0 0 1 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 00 1 00 1 00 24 1 0
br_c      1 00 00 00 0 0 0 1 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 00 1 00 1 00 24 2 0
br_full   1 00 00 00 0 0 0 1 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 0 00 0 00 0 00 00 3 1
del_chk   0 00 00 00 0 0 0 0 0 00 00 0 00 00 0 00 00 0 00 0 0 1 0 0 00 0 00 0 00 00 3 0
br_d      1 00 00 00 0 0 0 1 0 00 00 0 00 00 0 00 00 0 00 0 0 0 0 1 00 1 00 1 00 24 3 0

// ==== bench/tb_rename_core.sv ====
// --------------------
// Testbench for rename_core driven by the vectors in bench/rename_tests.txt
// Drains the free list first and then resets and replays the file
// --------------------

module tb_rename_core
    import isa_pkg::*, rename_pkg::*;
();

    typedef struct packed {
        logic          valid;
        reg_t          rs1, rs2, rd;
        logic          use1, use2, wr, br;
        logic          wbv0;
        reg_t          wbr0;
        phreg_t        wbp0;
        logic          wbv1;
        reg_t          wbr1;
        phreg_t        wbp1;
        logic          cw;
        reg_t          crd;
        phreg_t        cnew;
        logic          crel;
        phreg_t        cold;
        logic          rec;
        checkpoint_ptr rchk;
        logic          del, rcom;
        logic          e_valid;        // Expected outputs from here on
        phreg_t        e_src1;
        logic          e_rdy1;
        phreg_t        e_src2;
        logic          e_rdy2;
        phreg_t        e_old, e_new;
        checkpoint_ptr e_chk;
        logic          e_stall;
    } vec_t;

    logic clk_i, rstn_i, valid_i, use_rs1_i, use_rs2_i, write_rd_i, branch_i;
    reg_t rs1_i, rs2_i, rd_i, commit_rd_i;
    logic [NUM_SCALAR_WB-1:0] wb_valid_i;
    reg_t [NUM_SCALAR_WB-1:0] wb_vreg_i;
    phreg_t [NUM_SCALAR_WB-1:0] wb_preg_i;
    logic commit_write_i, commit_release_i, do_recover_i, delete_checkpoint_i;
    logic recover_commit_i;
    phreg_t commit_new_reg_i, commit_old_reg_i;
    checkpoint_ptr recover_checkpoint_i, checkpoint_o;
    logic valid_o, rdy1_o, rdy2_o, stall_o;
    phreg_t src1_o, src2_o, old_dst_o, new_dst_o;

    vec_t        vecs[$];
    string       names[$];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit  = 1000;   // Replaced once the file is read
    logic [31:0] lfsr   = 32'h3e9b;

    rename_core u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run exceeded %0d cycles", limit);
            $display("Test FAILED");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic take_bit();
        logic b;
        b    = lfsr[0];
        lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    function automatic reg_t random_rd();
        reg_t r;
        for (int i = 0; i < $bits(reg_t); i++) r[i] = take_bit();
        return (r == '0) ? reg_t'(31) : r;  // Only registers that take a new mapping
    endfunction

    task automatic check_phreg(input string test, input string what,
                               input phreg_t exp, input phreg_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s %s: expected %0h, actual %0h", test, what, exp, act);
        end
    endtask

    task automatic check_logic(input string test, input string what,
                               input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s %s: expected %0b, actual %0b", test, what, exp, act);
        end
    endtask

    task automatic check_chk(input string test, input checkpoint_ptr exp,
                             input checkpoint_ptr act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s checkpoint_o: expected %0h, actual %0h", test, exp, act);
        end
    endtask

    task automatic drive(input vec_t v);
        valid_i              = v.valid;
        rs1_i                = v.rs1;
        rs2_i                = v.rs2;
        rd_i                 = v.rd;
        use_rs1_i            = v.use1;
        use_rs2_i            = v.use2;
        write_rd_i           = v.wr;
        branch_i             = v.br;
        wb_valid_i           = {v.wbv1, v.wbv0};  // Port 0 in the low bits
        wb_vreg_i            = {v.wbr1, v.wbr0};
        wb_preg_i            = {v.wbp1, v.wbp0};
        commit_write_i       = v.cw;
        commit_rd_i          = v.crd;
        commit_new_reg_i     = v.cnew;
        commit_release_i     = v.crel;
        commit_old_reg_i     = v.cold;
        do_recover_i         = v.rec;
        recover_checkpoint_i = v.rchk;
        delete_checkpoint_i  = v.del;
        recover_commit_i     = v.rcom;
    endtask

    task automatic load_tests();
        int    fd;
        int    n;
        int    t [32];
        string line;
        string nm;
        vec_t  v;
        fd = $fopen("bench/rename_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open bench/rename_tests.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;  // Blank or column notes
            n = $sscanf(line, "%s%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                        nm, t[0], t[1], t[2], t[3], t[4], t[5], t[6], t[7],
                        t[8], t[9], t[10], t[11], t[12], t[13], t[14], t[15],
                        t[16], t[17], t[18], t[19], t[20], t[21], t[22], t[23],
                        t[24], t[25], t[26], t[27], t[28], t[29], t[30], t[31]);
            if (n != 33) begin
                errors++;
                $display("Test line could not be read: %s", line);
                continue;
            end
            v = {t[0][0], reg_t'(t[1]), reg_t'(t[2]), reg_t'(t[3]),
                 t[4][0], t[5][0], t[6][0], t[7][0],
                 t[8][0], reg_t'(t[9]), phreg_t'(t[10]),
                 t[11][0], reg_t'(t[12]), phreg_t'(t[13]),
                 t[14][0], reg_t'(t[15]), phreg_t'(t[16]), t[17][0], phreg_t'(t[18]),
                 t[19][0], checkpoint_ptr'(t[20]), t[21][0], t[22][0],
                 t[23][0], phreg_t'(t[24]), t[25][0], phreg_t'(t[26]), t[27][0],
                 phreg_t'(t[28]), phreg_t'(t[29]), checkpoint_ptr'(t[30]), t[31][0]};
            vecs.push_back(v);
            names.push_back(nm);
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        drive('0);
        rstn_i = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i) rstn_i = 1'b1;
    endtask

    // Pops every free register in order so that the last write stalls
    task automatic exhaust_free_list();
        phreg_t shadow [NUM_ISA_REGISTERS];  // Expected map of each register
        reg_t   last_rd;                     // Renamed a cycle ago, never written back
        vec_t   v;
        for (int r = 0; r < NUM_ISA_REGISTERS; r++) shadow[r] = phreg_t'(r);
        last_rd = '0;
        v = '0;
        for (int i = 0; i <= NUM_FREE; i++) begin
            v.valid = 1'b1;
            v.wr    = 1'b1;
            v.rd    = random_rd();
            v.rs1   = last_rd;
            v.use1  = 1'b0;  // Pending but unused reads ready
            v.rs2   = last_rd;
            v.use2  = 1'b1;  // Pending and used reads not ready
            drive(v);
            #2 check_logic("drain", "stall_o", (i == NUM_FREE), stall_o);
            @(negedge clk_i);
            check_logic("drain", "valid_o", (i < NUM_FREE), valid_o);
            if (i < NUM_FREE) begin
                check_phreg("drain", "new_dst_o", phreg_t'(NUM_ISA_REGISTERS + i), new_dst_o);
                check_phreg("drain", "old_dst_o", shadow[v.rd], old_dst_o);
                check_phreg("drain", "src1_o", shadow[last_rd], src1_o);
                check_logic("drain", "rdy1_o", 1'b1, rdy1_o);
                check_phreg("drain", "src2_o", shadow[last_rd], src2_o);
                check_logic("drain", "rdy2_o", (last_rd == '0), rdy2_o);  // x0 is never renamed
                shadow[v.rd] = phreg_t'(NUM_ISA_REGISTERS + i);
            end
            last_rd = v.rd;
        end
        drive('0);
    endtask

    initial begin
        drive('0);
        rstn_i = 1'b0;
        load_tests();
        limit = 4 * (vecs.size() + NUM_FREE + 1) + 20;
        apply_reset();
        exhaust_free_list();
        apply_reset();
        foreach (vecs[k]) begin
            drive(vecs[k]);
            #2 check_logic(names[k], "stall_o", vecs[k].e_stall, stall_o);  // Combinational
            @(negedge clk_i);
            check_logic(names[k], "valid_o", vecs[k].e_valid, valid_o);
            check_chk(names[k], vecs[k].e_chk, checkpoint_o);
            if (vecs[k].e_valid) begin
                check_phreg(names[k], "src1_o", vecs[k].e_src1, src1_o);
                check_logic(names[k], "rdy1_o", vecs[k].e_rdy1, rdy1_o);
                check_phreg(names[k], "src2_o", vecs[k].e_src2, src2_o);
                check_logic(names[k], "rdy2_o", vecs[k].e_rdy2, rdy2_o);
                check_phreg(names[k], "old_dst_o", vecs[k].e_old, old_dst_o);
                check_phreg(names[k], "new_dst_o", vecs[k].e_new, new_dst_o);
            end
        end
        drive('0);
        $display("Summary: %0d errors in %0d checks over %0d vectors", errors, checks,
                 vecs.size());
        if (errors == 0 && vecs.size() > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/free_list.sv ====
// --------------------
// Circular list of unused physical registers
// Read pointer is saved per checkpoint label and restored on recovery
// --------------------

module free_list
    import isa_pkg::*, rename_pkg::*;
(
    input  logic          clk_i,
    input  logic          rstn_i,
    freelist_if.list      fl,
    input  logic          commit_release_i,      // Old mapping retired
    input  phreg_t        commit_old_reg_i,
    input  logic          do_recover_i,
    input  checkpoint_ptr recover_checkpoint_i,
    input  logic          recover_commit_i
);

    typedef logic [$clog2(NUM_FREE):0] fl_cnt_t;  // Holds 0 to NUM_FREE

    phreg_t        list_q [NUM_FREE];
    free_ptr_t     saved_rd [NUM_CHECKPOINTS];  // Read pointer per label
    free_ptr_t     rd_ptr;
    free_ptr_t     wr_ptr;
    free_ptr_t     rd_nxt;
    free_ptr_t     wr_nxt;
    fl_cnt_t       count;
    checkpoint_ptr head;  // Tracks the table's current copy

    assign rd_nxt = rd_ptr + free_ptr_t'(fl.alloc);
    assign wr_nxt = wr_ptr + free_ptr_t'(commit_release_i);

    assign fl.free_reg = list_q[rd_ptr];
    assign fl.empty    = (count == '0);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            // Everything above the architectural registers starts free
            for (int i = 0; i < NUM_FREE; i++) begin
                list_q[i] <= phreg_t'(NUM_ISA_REGISTERS + i);
            end
            for (int c = 0; c < NUM_CHECKPOINTS; c++) begin
                saved_rd[c] <= '0;
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= fl_cnt_t'(NUM_FREE);
            head   <= '0;
        end else begin
            if (commit_release_i)
                list_q[wr_ptr] <= commit_old_reg_i;
            wr_ptr <= wr_nxt;

            if (recover_commit_i) begin
                // Every slot is free again, oldest at the tail
                rd_ptr <= wr_nxt;
                count  <= fl_cnt_t'(NUM_FREE);
                head   <= '0;
            end else if (do_recover_i) begin
                // Give back what was popped since the label
                rd_ptr <= saved_rd[recover_checkpoint_i];
                count  <= count + fl_cnt_t'(free_ptr_t'(rd_ptr - saved_rd[recover_checkpoint_i]))
                                + fl_cnt_t'(commit_release_i);
                head   <= recover_checkpoint_i;
            end else begin
                rd_ptr <= rd_nxt;
                count  <= count - fl_cnt_t'(fl.alloc) + fl_cnt_t'(commit_release_i);
                if (fl.do_checkpoint) begin
                    saved_rd[head] <= rd_nxt;  // After the branch's own allocation
                    head           <= head + checkpoint_ptr'(1);
                end
            end
        end
    end

endmodule

// ==== hdl/isa_pkg.sv ====
// --------------------
// RISC-V architectural register definitions
// Imported by every block that names an ISA register
// --------------------

package isa_pkg;

    // Integer register file of the base ISA
    localparam int NUM_ISA_REGISTERS = 32;

    // Architectural register index, x0 to x31
    typedef logic [$clog2(NUM_ISA_REGISTERS)-1:0] reg_t;

endpackage

// ==== hdl/rename_core.sv ====
// --------------------
// Rename stage top level
// Front end, write-back and commit connect through plain ports
// --------------------

module rename_core
    import isa_pkg::*, rename_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rstn_i,
    // Decoded instruction
    input  logic                              valid_i,
    input  reg_t                              rs1_i,
    input  reg_t                              rs2_i,
    input  reg_t                              rd_i,
    input  logic                              use_rs1_i,
    input  logic                              use_rs2_i,
    input  logic                              write_rd_i,
    input  logic                              branch_i,
    // Write-back ports
    input  logic          [NUM_SCALAR_WB-1:0] wb_valid_i,
    input  reg_t          [NUM_SCALAR_WB-1:0] wb_vreg_i,
    input  phreg_t        [NUM_SCALAR_WB-1:0] wb_preg_i,
    // Commit
    input  logic                              commit_write_i,
    input  reg_t                              commit_rd_i,
    input  phreg_t                            commit_new_reg_i,
    input  logic                              commit_release_i,
    input  phreg_t                            commit_old_reg_i,
    // Recovery
    input  logic                              do_recover_i,
    input  checkpoint_ptr                     recover_checkpoint_i,
    input  logic                              delete_checkpoint_i,
    input  logic                              recover_commit_i,
    // Renamed instruction, one cycle later
    output logic                              valid_o,
    output phreg_t                            src1_o,
    output logic                              rdy1_o,
    output phreg_t                            src2_o,
    output logic                              rdy2_o,
    output phreg_t                            old_dst_o,
    output phreg_t                            new_dst_o,
    output checkpoint_ptr                     checkpoint_o,
    output logic                              stall_o
);

    table_if    u_table_if ();
    freelist_if u_freelist_if ();

    rename_ctrl u_ctrl (
        .clk_i, .rstn_i, .valid_i, .rs1_i, .rs2_i, .rd_i,
        .use_rs1_i, .use_rs2_i, .write_rd_i, .branch_i,
        .do_recover_i, .recover_commit_i,
        .tbl (u_table_if.ctrl),
        .fl  (u_freelist_if.ctrl),
        .valid_o, .src1_o, .rdy1_o, .src2_o, .rdy2_o,
        .old_dst_o, .new_dst_o, .checkpoint_o, .stall_o
    );

    rename_table u_table (
        .clk_i, .rstn_i,
        .tbl (u_table_if.tbl),
        .wb_valid_i, .wb_vreg_i, .wb_preg_i,
        .commit_write_i, .commit_rd_i, .commit_new_reg_i,
        .do_recover_i, .recover_checkpoint_i, .delete_checkpoint_i, .recover_commit_i
    );

    free_list u_free_list (
        .clk_i, .rstn_i,
        .fl (u_freelist_if.list),
        .commit_release_i, .commit_old_reg_i,
        .do_recover_i, .recover_checkpoint_i, .recover_commit_i
    );

endmodule

// ==== hdl/rename_ctrl.sv ====
// --------------------
// Rename gating, allocation and stall
// Aligns the allocated register with the table's registered outputs
// --------------------

module rename_ctrl
    import isa_pkg::*, rename_pkg::*;
(
    input  logic          clk_i,
    input  logic          rstn_i,
    input  logic          valid_i,
    input  reg_t          rs1_i,
    input  reg_t          rs2_i,
    input  reg_t          rd_i,
    input  logic          use_rs1_i,
    input  logic          use_rs2_i,
    input  logic          write_rd_i,
    input  logic          branch_i,
    input  logic          do_recover_i,
    input  logic          recover_commit_i,
    table_if.ctrl         tbl,
    freelist_if.ctrl      fl,
    output logic          valid_o,
    output phreg_t        src1_o,
    output logic          rdy1_o,
    output phreg_t        src2_o,
    output logic          rdy2_o,
    output phreg_t        old_dst_o,
    output phreg_t        new_dst_o,
    output checkpoint_ptr checkpoint_o,
    output logic          stall_o
);

    logic recovering;
    logic needs_reg;  // Writes to x0 take no register
    logic go;         // Instruction is renamed this cycle

    assign recovering = do_recover_i | recover_commit_i;
    assign needs_reg  = write_rd_i & (rd_i != '0);

    // Out of registers, or a branch with no copy left
    assign stall_o = valid_i & ((needs_reg & fl.empty) | (branch_i & tbl.out_of_checkpoints));
    assign go      = valid_i & ~stall_o & ~recovering;

    assign tbl.read_src1     = rs1_i;
    assign tbl.read_src2     = rs2_i;
    assign tbl.old_dst       = rd_i;
    assign tbl.use_rs1       = use_rs1_i;
    assign tbl.use_rs2       = use_rs2_i;
    assign tbl.new_dst       = fl.free_reg;
    assign tbl.write_dst     = go & needs_reg;  // Same cycle as the pop
    assign fl.alloc          = go & needs_reg;
    assign tbl.do_checkpoint = go & branch_i;
    assign fl.do_checkpoint  = go & branch_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) valid_o <= 1'b0;
        else         valid_o <= go;
    end

    // Head entry lines up with the table lookup
    always_ff @(posedge clk_i) new_dst_o <= fl.free_reg;

    assign src1_o       = tbl.src1;
    assign rdy1_o       = tbl.rdy1;
    assign src2_o       = tbl.src2;
    assign rdy2_o       = tbl.rdy2;
    assign old_dst_o    = tbl.old_dst_map;
    assign checkpoint_o = tbl.checkpoint;

endmodule

// ==== hdl/rename_ifs.sv ====
// --------------------
// Buses between rename control, map table and free list
// Control side uses modport ctrl on both
// --------------------

// Lookup and update of the map table
interface table_if
    import isa_pkg::*, rename_pkg::*;
();

    reg_t          read_src1;
    reg_t          read_src2;
    reg_t          old_dst;             // Destination to read and remap
    logic          use_rs1;
    logic          use_rs2;
    logic          write_dst;           // Remap old_dst to new_dst
    phreg_t        new_dst;
    logic          do_checkpoint;       // Save current map into the next copy

    phreg_t        src1;
    logic          rdy1;
    phreg_t        src2;
    logic          rdy2;
    phreg_t        old_dst_map;         // Previous mapping of the destination
    checkpoint_ptr checkpoint;
    logic          out_of_checkpoints;

    modport ctrl (
        output read_src1, read_src2, old_dst, use_rs1, use_rs2,
        output write_dst, new_dst, do_checkpoint,
        input  src1, rdy1, src2, rdy2, old_dst_map, checkpoint, out_of_checkpoints
    );

    // Table side, the name table is a reserved word
    modport tbl (
        input  read_src1, read_src2, old_dst, use_rs1, use_rs2,
        input  write_dst, new_dst, do_checkpoint,
        output src1, rdy1, src2, rdy2, old_dst_map, checkpoint, out_of_checkpoints
    );

endinterface

// Allocation from the free list
interface freelist_if
    import rename_pkg::*;
();

    logic   alloc;          // Pop the head entry
    logic   do_checkpoint;  // Save read pointer with the table copy
    phreg_t free_reg;       // Head entry, valid while not empty
    logic   empty;

    modport ctrl (output alloc, do_checkpoint, input free_reg, empty);
    modport list (input alloc, do_checkpoint, output free_reg, empty);

endinterface

// ==== hdl/rename_pkg.sv ====
// --------------------
// Sizes and types of the rename stage
// Physical registers, checkpoints and write-back ports
// --------------------

package rename_pkg;
    import isa_pkg::*;

    localparam int NUM_PHYS_REGISTERS = 64;
    // Registers not held by the architectural map
    localparam int NUM_FREE = NUM_PHYS_REGISTERS - NUM_ISA_REGISTERS;

    localparam int NUM_CHECKPOINTS = 4;  // Speculative map copies
    localparam int NUM_SCALAR_WB   = 2;  // Write-back ports that set ready bits

    // Physical register index
    typedef logic [$clog2(NUM_PHYS_REGISTERS)-1:0] phreg_t;

    // Label of a map copy
    typedef logic [$clog2(NUM_CHECKPOINTS)-1:0] checkpoint_ptr;

    // Slot in the circular free list
    typedef logic [$clog2(NUM_FREE)-1:0] free_ptr_t;

endpackage

// ==== hdl/rename_table.sv ====
// --------------------
// Register map table with checkpoint copies and ready bits
// Reads are registered, write-back readiness bypasses into them
// --------------------

module rename_table
    import isa_pkg::*, rename_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rstn_i,
    table_if.tbl                              tbl,
    input  logic          [NUM_SCALAR_WB-1:0] wb_valid_i,
    input  reg_t          [NUM_SCALAR_WB-1:0] wb_vreg_i,
    input  phreg_t        [NUM_SCALAR_WB-1:0] wb_preg_i,
    input  logic                              commit_write_i,
    input  reg_t                              commit_rd_i,
    input  phreg_t                            commit_new_reg_i,
    input  logic                              do_recover_i,
    input  checkpoint_ptr                     recover_checkpoint_i,
    input  logic                              delete_checkpoint_i,
    input  logic                              recover_commit_i
);

    typedef logic [$clog2(NUM_CHECKPOINTS):0] chk_cnt_t;  // One bit wider than a label

    phreg_t map_q [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    logic   rdy_q [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    phreg_t commit_q [NUM_ISA_REGISTERS];  // Map of retired state

    checkpoint_ptr head;      // Copy in use
    checkpoint_ptr tail;      // Oldest live checkpoint
    checkpoint_ptr nxt;
    checkpoint_ptr tail_nxt;
    chk_cnt_t      count;     // Live checkpoints

    logic [NUM_ISA_REGISTERS-1:0] wb_cur;  // Write-back hits on the current copy

    assign nxt      = head + checkpoint_ptr'(1);
    assign tail_nxt = tail + checkpoint_ptr'(delete_checkpoint_i);

    // Keep one copy for the running map
    assign tbl.out_of_checkpoints = (count == chk_cnt_t'(NUM_CHECKPOINTS - 1));

    // A port only hits if the register still maps to that physical register
    always_comb begin
        wb_cur = '0;
        for (int i = 0; i < NUM_SCALAR_WB; i++) begin
            if (wb_valid_i[i] && (map_q[head][wb_vreg_i[i]] == wb_preg_i[i])) begin
                wb_cur[wb_vreg_i[i]] = 1'b1;
            end
        end
    end

    // Registered lookups, unused sources count as ready
    always_ff @(posedge clk_i) begin
        tbl.src1        <= map_q[head][tbl.read_src1];
        tbl.rdy1        <= rdy_q[head][tbl.read_src1] | wb_cur[tbl.read_src1] | ~tbl.use_rs1;
        tbl.src2        <= map_q[head][tbl.read_src2];
        tbl.rdy2        <= rdy_q[head][tbl.read_src2] | wb_cur[tbl.read_src2] | ~tbl.use_rs2;
        tbl.old_dst_map <= map_q[head][tbl.old_dst];
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int c = 0; c < NUM_CHECKPOINTS; c++) begin
                for (int r = 0; r < NUM_ISA_REGISTERS; r++) begin
                    map_q[c][r] <= phreg_t'(r);  // Identity map
                    rdy_q[c][r] <= 1'b1;
                end
            end
            for (int r = 0; r < NUM_ISA_REGISTERS; r++) begin
                commit_q[r] <= phreg_t'(r);
            end
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            tbl.checkpoint <= '0;
        end else begin
            // Write-back marks every copy that holds the mapping
            for (int i = 0; i < NUM_SCALAR_WB; i++) begin
                for (int c = 0; c < NUM_CHECKPOINTS; c++) begin
                    if (wb_valid_i[i] && (map_q[c][wb_vreg_i[i]] == wb_preg_i[i]))
                        rdy_q[c][wb_vreg_i[i]] <= 1'b1;
                end
            end

            // New copy gets this cycle's write-back hits too
            if (tbl.do_checkpoint) begin
                for (int r = 0; r < NUM_ISA_REGISTERS; r++) begin
                    map_q[nxt][r] <= map_q[head][r];
                    rdy_q[nxt][r] <= rdy_q[head][r] | wb_cur[r];
                end
                head <= nxt;
            end

            // Rename lands in both copies on a checkpoint
            if (tbl.write_dst) begin
                map_q[head][tbl.old_dst] <= tbl.new_dst;
                rdy_q[head][tbl.old_dst] <= 1'b0;
                if (tbl.do_checkpoint) begin
                    map_q[nxt][tbl.old_dst] <= tbl.new_dst;
                    rdy_q[nxt][tbl.old_dst] <= 1'b0;
                end
            end

            if (commit_write_i && (commit_rd_i != '0))
                commit_q[commit_rd_i] <= commit_new_reg_i;  // x0 stays fixed

            tail           <= tail_nxt;
            tbl.checkpoint <= head;  // Label that recovers to this rename

            if (recover_commit_i) begin
                // Flush everything back to the retired map
                for (int r = 0; r < NUM_ISA_REGISTERS; r++) begin
                    map_q[0][r] <= commit_q[r];
                    rdy_q[0][r] <= 1'b1;
                end
                head           <= '0;
                tail           <= '0;
                count          <= '0;
                tbl.checkpoint <= '0;
            end else if (do_recover_i) begin
                head  <= recover_checkpoint_i;
                count <= {1'b0, checkpoint_ptr'(recover_checkpoint_i - tail_nxt)};
            end else begin
                count <= count + chk_cnt_t'(tbl.do_checkpoint)
                               - chk_cnt_t'(delete_checkpoint_i);
            end
        end
    end

endmodule

// ==== rename_core.f ====
hdl/isa_pkg.sv
hdl/rename_pkg.sv
hdl/rename_ifs.sv
hdl/rename_table.sv
hdl/free_list.sv
hdl/rename_ctrl.sv
hdl/rename_core.sv
bench/rename_core_asserts.sv
bench/tb_rename_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the rename stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rename_core -Mdir obj_dir -f rename_core.f

out=$(./obj_dir/Vtb_rename_core)
echo "$out"

if grep -q "^Test OK$" <<< "$out"; then
    exit 0
else
    exit 1
fi
